//--- hw/virtio_defines.svh
`ifndef VIRTIO_DEFINES_SVH
`define VIRTIO_DEFINES_SVH

// register bus widths
`define VIRTIO_DATA_W 32
`define VIRTIO_ADDR_W 12

// --------------------------------------------------
// virtio-mmio register map
// --------------------------------------------------
`define REG_MAGIC         12'h000
`define REG_VERSION       12'h004
`define REG_DEVICE_ID     12'h008
`define REG_VENDOR_ID     12'h00c
`define REG_DEV_FEAT      12'h010
`define REG_DEV_FEAT_SEL  12'h014
`define REG_DRV_FEAT      12'h020
`define REG_DRV_FEAT_SEL  12'h024
`define REG_QUEUE_NUM_MAX 12'h034
`define REG_QUEUE_READY   12'h044
`define REG_QUEUE_NOTIFY  12'h050
`define REG_INT_STATUS    12'h060
`define REG_INT_ACK       12'h064
`define REG_STATUS        12'h070
`define REG_DESC_LO       12'h080
`define REG_DESC_HI       12'h084
`define REG_AVAIL_LO      12'h090
`define REG_AVAIL_HI      12'h094
`define REG_USED_LO       12'h0a0
`define REG_USED_HI       12'h0a4
`define REG_CONFIG_GEN    12'h0fc
`define REG_CAPACITY_LO   12'h100
`define REG_CAPACITY_HI   12'h104

// identity of the block device
`define MAGIC_VALUE      32'h7472_6976
`define VERSION          32'd2
`define DEVICE_ID        32'd2
`define VENDOR_ID        32'hff00_1af4
`define QUEUE_NUM_MAX    32'd16
// capacity in 512 byte sectors
`define CAPACITY_SECTORS 64'd4

// VERSION_1 (32) and ACCESS_PLATFORM (33)
`define DEVICE_FEATURES  64'h0000_0003_0000_0000

// device status bits
`define STATUS_ACK         0
`define STATUS_DRIVER      1
`define STATUS_DRIVER_OK   2
`define STATUS_FEATURES_OK 3

`endif

//--- hw/virtio_pkg.sv
`include "virtio_defines.svh"

package virtio_pkg;

	// --------------------------------------------------
	// scalar types
	// --------------------------------------------------
	typedef logic [`VIRTIO_ADDR_W-1:0] reg_addr_t;
	typedef logic [`VIRTIO_DATA_W-1:0] reg_data_t;

	// guest physical address of a ring
	typedef logic [63:0] guest_addr_t;

	// driver initialization sequence
	typedef enum logic [1:0]
	{
		INIT_RESET    = 2'd0,
		INIT_FEATURES = 2'd1,
		INIT_DRIVER   = 2'd2,
		INIT_READY    = 2'd3
	} init_state_t;

	// --------------------------------------------------
	// register access strobes
	// --------------------------------------------------
	typedef struct packed
	{
		logic      en;
		reg_addr_t addr;
		reg_data_t data;
	} reg_wr_t;

	typedef struct packed
	{
		logic      en;
		reg_addr_t addr;
	} reg_rd_t;

	// configuration of the single virtqueue
	typedef struct packed
	{
		logic        ready;
		guest_addr_t desc;
		guest_addr_t avail;
		guest_addr_t used;
	} vq_cfg_t;

endpackage

//--- hw/virtio_axi_slave.sv
module virtio_axi_slave
(
	input  logic                 axi_aclk,
	input  logic                 axi_aresetn,

	// write address and data
	input  virtio_pkg::reg_addr_t awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  virtio_pkg::reg_data_t wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,

	// write response
	output logic [1:0]           bresp,
	output logic                 bvalid,
	input  logic                 bready,

	// read address and data
	input  virtio_pkg::reg_addr_t araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output virtio_pkg::reg_data_t rdata,
	output logic [1:0]           rresp,
	output logic                 rvalid,
	input  logic                 rready,

	// register side
	output virtio_pkg::reg_wr_t   reg_wr,
	output virtio_pkg::reg_rd_t   reg_rd,
	input  virtio_pkg::reg_data_t rd_data
);

	logic wr_busy;
	logic rd_busy;
	logic wr_start;
	logic rd_start;
	logic wr_fire;
	logic rd_fire;

	// --------------------------------------------------
	// arbitration
	// --------------------------------------------------
	// a transfer is busy from its ready pulse until the response is taken
	assign wr_busy = awready || bvalid;
	assign rd_busy = arready || rvalid;

	assign wr_start = awvalid && wvalid && !wr_busy && !rd_busy;
	// write wins when both arrive together
	assign rd_start = arvalid && !rd_busy && !wr_busy && !wr_start;

	assign wr_fire = awready && awvalid && wvalid;
	assign rd_fire = arready && arvalid;

	// --------------------------------------------------
	// write channel
	// --------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
		end
		else
		begin
			// address and data are taken together, one cycle only
			awready <= wr_start;
			wready  <= wr_start;
		end
	end

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	// all registers are full word, wstrb has no effect
	always_comb
	begin
		reg_wr.en   = wr_fire;
		reg_wr.addr = awaddr;
		reg_wr.data = wdata;
	end

	// --------------------------------------------------
	// read channel
	// --------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			arready <= 1'b0;
		else
			arready <= rd_start;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// capture the mux output in the address cycle
	always_ff @(posedge axi_aclk)
	begin
		if (rd_fire)
			rdata <= rd_data;
	end

	always_comb
	begin
		reg_rd.en   = rd_fire;
		reg_rd.addr = araddr;
	end

	// OKAY on every response
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// response stays up until the host takes it
	a_bvalid_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		bvalid && !bready |=> bvalid);

	// no new write accepted while a response waits
	a_no_aw_under_b: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		bvalid |-> !$rose(awready));

endmodule

//--- hw/virtio_status_fsm.sv
`include "virtio_defines.svh"

module virtio_status_fsm
(
	input  logic                     axi_aclk,
	input  logic                     axi_aresetn,
	input  virtio_pkg::reg_wr_t       reg_wr,
	output virtio_pkg::reg_data_t     device_status,
	output virtio_pkg::init_state_t   init_state
);

	import virtio_pkg::*;

	logic status_wr;
	logic status_clr;

	assign status_wr  = reg_wr.en && (reg_wr.addr == `REG_STATUS);
	// writing zero restarts the driver handshake
	assign status_clr = status_wr && (reg_wr.data == '0);

	// --------------------------------------------------
	// status register
	// --------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			device_status <= '0;
		else if (status_clr)
			device_status <= reg_data_t'(1) << `STATUS_ACK;
		else if (status_wr)
		begin
			// each bit only counts in the step it belongs to
			if (init_state == INIT_RESET && reg_wr.data[`STATUS_DRIVER])
				device_status[`STATUS_DRIVER] <= 1'b1;
			else if (init_state == INIT_FEATURES && reg_wr.data[`STATUS_FEATURES_OK])
				device_status[`STATUS_FEATURES_OK] <= 1'b1;
			else if (init_state == INIT_DRIVER && reg_wr.data[`STATUS_DRIVER_OK])
				device_status[`STATUS_DRIVER_OK] <= 1'b1;
		end
	end

	// --------------------------------------------------
	// init sequence, follows the status one edge later
	// --------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			init_state <= INIT_RESET;
		else if (status_clr)
			init_state <= INIT_RESET;
		else
		begin
			case (init_state)
				INIT_RESET:
					if (device_status[`STATUS_DRIVER])
						init_state <= INIT_FEATURES;
				INIT_FEATURES:
					if (device_status[`STATUS_FEATURES_OK])
						init_state <= INIT_DRIVER;
				INIT_DRIVER:
					if (device_status[`STATUS_DRIVER_OK])
						init_state <= INIT_READY;
				INIT_READY:
					init_state <= INIT_READY;
			endcase
		end
	end

	a_ready_has_driver_ok: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		init_state == INIT_READY |-> device_status[`STATUS_DRIVER_OK]);

endmodule

//--- hw/virtio_regfile.sv
`include "virtio_defines.svh"

module virtio_regfile
(
	input  logic                   axi_aclk,
	input  logic                   axi_aresetn,
	input  virtio_pkg::reg_wr_t     reg_wr,
	input  virtio_pkg::reg_rd_t     reg_rd,
	output virtio_pkg::reg_data_t   rd_data,
	input  virtio_pkg::reg_data_t   device_status,
	input  virtio_pkg::init_state_t init_state,
	output virtio_pkg::vq_cfg_t     vq_cfg,
	output logic                   interrupt,
	output logic                   queue_notify
);

	import virtio_pkg::*;

	localparam logic [63:0] dev_features = `DEVICE_FEATURES;
	localparam logic [63:0] capacity     = `CAPACITY_SECTORS;

	reg_data_t   dev_feat_sel;
	reg_data_t   drv_feat_sel;
	logic [63:0] drv_features;
	vq_cfg_t     vq_q;
	logic        int_status;
	logic        int_d;

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			dev_feat_sel <= '0;
			drv_feat_sel <= '0;
			drv_features <= '0;
			vq_q         <= '0;
			int_status   <= 1'b0;
		end
		else if (reg_wr.en)
		begin
			case (reg_wr.addr)
				`REG_DEV_FEAT_SEL: dev_feat_sel <= reg_wr.data;
				`REG_DRV_FEAT_SEL: drv_feat_sel <= reg_wr.data;
				`REG_DRV_FEAT:
				begin
					// only taken while features are negotiated
					if (init_state == INIT_FEATURES)
					begin
						if (drv_feat_sel == '0)
							drv_features[31:0] <= reg_wr.data;
						else
							drv_features[63:32] <= reg_wr.data;
					end
				end
				`REG_QUEUE_READY:  vq_q.ready        <= reg_wr.data[0];
				`REG_DESC_LO:      vq_q.desc[31:0]   <= reg_wr.data;
				`REG_DESC_HI:      vq_q.desc[63:32]  <= reg_wr.data;
				`REG_AVAIL_LO:     vq_q.avail[31:0]  <= reg_wr.data;
				`REG_AVAIL_HI:     vq_q.avail[63:32] <= reg_wr.data;
				`REG_USED_LO:      vq_q.used[31:0]   <= reg_wr.data;
				`REG_USED_HI:      vq_q.used[63:32]  <= reg_wr.data;
				// notify raises the used buffer interrupt, ack clears it
				`REG_QUEUE_NOTIFY: int_status <= 1'b1;
				`REG_INT_ACK:      int_status <= int_status & ~reg_wr.data[0];
				default: ;
			endcase
		end
	end

	assign vq_cfg    = vq_q;
	assign interrupt = int_status;

	// --------------------------------------------------
	// notify pulse on the rising edge of the interrupt bit
	// --------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			int_d        <= 1'b0;
			queue_notify <= 1'b0;
		end
		else
		begin
			int_d        <= int_status;
			queue_notify <= int_status && !int_d;
		end
	end

	// --------------------------------------------------
	// read mux
	// --------------------------------------------------
	always_comb
	begin
		rd_data = '0;
		if (reg_rd.en)
		begin
			case (reg_rd.addr)
				`REG_MAGIC:         rd_data = `MAGIC_VALUE;
				`REG_VERSION:       rd_data = `VERSION;
				`REG_DEVICE_ID:     rd_data = `DEVICE_ID;
				`REG_VENDOR_ID:     rd_data = `VENDOR_ID;
				`REG_DEV_FEAT:
					rd_data = (dev_feat_sel == '0) ? dev_features[31:0] : dev_features[63:32];
				`REG_DRV_FEAT:
					rd_data = (drv_feat_sel == '0) ? drv_features[31:0] : drv_features[63:32];
				`REG_QUEUE_NUM_MAX: rd_data = `QUEUE_NUM_MAX;
				`REG_QUEUE_READY:   rd_data = reg_data_t'(vq_q.ready);
				`REG_INT_STATUS:    rd_data = reg_data_t'(int_status);
				`REG_STATUS:        rd_data = device_status;
				// config space never changes
				`REG_CONFIG_GEN:    rd_data = '0;
				`REG_CAPACITY_LO:   rd_data = capacity[31:0];
				`REG_CAPACITY_HI:   rd_data = capacity[63:32];
				default:            rd_data = '0;
			endcase
		end
	end

	a_notify_single: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		queue_notify |=> !queue_notify);

endmodule

//--- hw/virtio_mmio_top.sv
module virtio_mmio_top
(
	input  logic                   axi_aclk,
	input  logic                   axi_aresetn,

	input  virtio_pkg::reg_addr_t   awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  virtio_pkg::reg_data_t   wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  virtio_pkg::reg_addr_t   araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output virtio_pkg::reg_data_t   rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,

	// towards the block processor
	output virtio_pkg::vq_cfg_t     vq_cfg,
	output logic                   interrupt,
	output logic                   queue_notify
);

	import virtio_pkg::*;

	reg_wr_t     reg_wr;
	reg_rd_t     reg_rd;
	reg_data_t   rd_data;
	reg_data_t   device_status;
	init_state_t init_state;

	// --------------------------------------------------
	// bus front end
	// --------------------------------------------------
	virtio_axi_slave u_axi_slave
	(
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.reg_wr      (reg_wr),
		.reg_rd      (reg_rd),
		.rd_data     (rd_data)
	);

	virtio_status_fsm u_status_fsm
	(
		.axi_aclk      (axi_aclk),
		.axi_aresetn   (axi_aresetn),
		.reg_wr        (reg_wr),
		.device_status (device_status),
		.init_state    (init_state)
	);

	virtio_regfile u_regfile
	(
		.axi_aclk      (axi_aclk),
		.axi_aresetn   (axi_aresetn),
		.reg_wr        (reg_wr),
		.reg_rd        (reg_rd),
		.rd_data       (rd_data),
		.device_status (device_status),
		.init_state    (init_state),
		.vq_cfg        (vq_cfg),
		.interrupt     (interrupt),
		.queue_notify  (queue_notify)
	);

endmodule

//--- sim/tb_virtio_mmio.sv
`include "virtio_defines.svh"

module tb_virtio_mmio;

	timeunit 1ns;
	timeprecision 1ps;

	import virtio_pkg::*;

	localparam int TIMEOUT = 50;

	logic       axi_aclk = 1'b0;
	logic       axi_aresetn;
	reg_addr_t  awaddr;
	logic       awvalid;
	logic       awready;
	reg_data_t  wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	reg_addr_t  araddr;
	logic       arvalid;
	logic       arready;
	reg_data_t  rdata;
	logic [1:0] rresp;
	logic       rvalid;
	logic       rready;
	vq_cfg_t    vq_cfg;
	logic       interrupt;
	logic       queue_notify;

	// last compared value and last response latency
	string      check_name;
	reg_data_t  check_exp;
	reg_data_t  check_act;
	logic       check_en;
	string      lat_name;
	int         lat_act;
	logic       lat_en;

	integer     seed = 32'ha874;
	int         notify_count = 0;
	reg_data_t  rnd [6];
	reg_addr_t  ring_regs [6];

	virtio_mmio_top uut (.*);

	always #4 axi_aclk = ~axi_aclk;

	// one count per notify pulse, sampled away from the rising edge
	always @(negedge axi_aclk)
	begin
		if (queue_notify)
			notify_count <= notify_count + 1;
	end

	// --------------------------------------------------
	// checkers
	// --------------------------------------------------
	a_value: assert property (@(posedge axi_aclk) check_en |-> check_act == check_exp)
		else stop_with_failure($sformatf("[FAIL] %s expected %h actual %h",
			check_name, check_exp, check_act));

	// response two edges after the request
	a_latency: assert property (@(posedge axi_aclk) lat_en |-> lat_act == 2)
		else stop_with_failure($sformatf("[FAIL] %s latency expected 2 actual %0d",
			lat_name, lat_act));

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic compare_value(input string name, input reg_data_t exp, input reg_data_t act);
		@(posedge axi_aclk);
		check_name <= name;
		check_exp  <= exp;
		check_act  <= act;
		check_en   <= 1'b1;
		@(posedge axi_aclk);
		check_en <= 1'b0;
	endtask

	task automatic check_latency(input string name, input int edges);
		@(posedge axi_aclk);
		lat_name <= name;
		lat_act  <= edges;
		lat_en   <= 1'b1;
		@(posedge axi_aclk);
		lat_en <= 1'b0;
	endtask

	// --------------------------------------------------
	// bus accesses
	// --------------------------------------------------
	task automatic write_reg(input string name, input reg_addr_t addr, input reg_data_t data);
		int         edges;
		logic [1:0] resp;
		@(posedge axi_aclk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		edges = 0;
		@(negedge axi_aclk);
		while (!(awready && wready) && edges < TIMEOUT)
		begin
			@(negedge axi_aclk);
			edges++;
		end
		if (!(awready && wready))
			stop_with_failure({name, ": awready and wready never came"});
		// address and data are taken on this edge
		@(posedge axi_aclk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		edges++;
		@(negedge axi_aclk);
		while (!bvalid && edges < TIMEOUT)
		begin
			@(negedge axi_aclk);
			edges++;
		end
		if (!bvalid)
			stop_with_failure({name, ": no write response"});
		resp = bresp;
		check_latency({name, " write"}, edges);
		// OKAY response
		compare_value({name, " bresp"}, 32'd0, 32'(resp));
	endtask

	task automatic read_expect(input string name, input reg_addr_t addr, input reg_data_t exp);
		int         edges;
		reg_data_t  data;
		logic [1:0] resp;
		@(posedge axi_aclk);
		araddr  <= addr;
		arvalid <= 1'b1;
		edges = 0;
		@(negedge axi_aclk);
		while (!arready && edges < TIMEOUT)
		begin
			@(negedge axi_aclk);
			edges++;
		end
		if (!arready)
			stop_with_failure({name, ": arready never came"});
		@(posedge axi_aclk);
		arvalid <= 1'b0;
		edges++;
		@(negedge axi_aclk);
		while (!rvalid && edges < TIMEOUT)
		begin
			@(negedge axi_aclk);
			edges++;
		end
		if (!rvalid)
			stop_with_failure({name, ": no read data"});
		data = rdata;
		resp = rresp;
		check_latency({name, " read"}, edges);
		compare_value(name, exp, data);
		compare_value({name, " rresp"}, 32'd0, 32'(resp));
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial
	begin
		reg_data_t drv_word;
		int        notify_base;
		int        waited;
		ring_regs = '{`REG_DESC_LO, `REG_DESC_HI, `REG_AVAIL_LO,
			`REG_AVAIL_HI, `REG_USED_LO, `REG_USED_HI};
		axi_aresetn <= 1'b0;
		awaddr      <= '0;
		awvalid     <= 1'b0;
		wdata       <= '0;
		wstrb       <= 4'h0;
		wvalid      <= 1'b0;
		araddr      <= '0;
		arvalid     <= 1'b0;
		bready      <= 1'b1;
		rready      <= 1'b1;
		check_en    <= 1'b0;
		lat_en      <= 1'b0;
		repeat (5) @(posedge axi_aclk);
		axi_aresetn <= 1'b1;
		compare_value("idle handshakes", 32'd0, 32'({awready, wready, bvalid, arready, rvalid}));

		// identity registers
		read_expect("magic", `REG_MAGIC, 32'h7472_6976);
		read_expect("version", `REG_VERSION, 32'd2);
		read_expect("device id", `REG_DEVICE_ID, 32'd2);
		read_expect("vendor id", `REG_VENDOR_ID, 32'hff00_1af4);
		read_expect("queue num max", `REG_QUEUE_NUM_MAX, 32'd16);
		read_expect("capacity lo", `REG_CAPACITY_LO, 32'd4);
		read_expect("capacity hi", `REG_CAPACITY_HI, 32'd0);
		read_expect("config generation", `REG_CONFIG_GEN, 32'd0);
		read_expect("unmapped offset", 12'h200, 32'd0);

		write_reg("dev feature select", `REG_DEV_FEAT_SEL, 32'd0);
		read_expect("dev features lo", `REG_DEV_FEAT, 32'd0);
		write_reg("dev feature select", `REG_DEV_FEAT_SEL, 32'd1);
		read_expect("dev features hi", `REG_DEV_FEAT, 32'd3);

		// status handshake, driver features locked until negotiation
		write_reg("status clear", `REG_STATUS, 32'd0);
		read_expect("status after clear", `REG_STATUS, 32'h1);
		drv_word = $random(seed);
		write_reg("drv feature select", `REG_DRV_FEAT_SEL, 32'd0);
		write_reg("drv features in reset", `REG_DRV_FEAT, drv_word);
		read_expect("drv features in reset", `REG_DRV_FEAT, 32'd0);
		write_reg("status driver", `REG_STATUS, 32'h3);
		read_expect("status driver", `REG_STATUS, 32'h3);
		write_reg("status early driver ok", `REG_STATUS, 32'h7);
		read_expect("status early driver ok", `REG_STATUS, 32'h3);
		write_reg("drv features lo", `REG_DRV_FEAT, drv_word);
		read_expect("drv features lo", `REG_DRV_FEAT, drv_word);
		drv_word = $random(seed);
		write_reg("drv feature select", `REG_DRV_FEAT_SEL, 32'd1);
		write_reg("drv features hi", `REG_DRV_FEAT, drv_word);
		read_expect("drv features hi", `REG_DRV_FEAT, drv_word);
		write_reg("status features ok", `REG_STATUS, 32'hb);
		read_expect("status features ok", `REG_STATUS, 32'hb);
		write_reg("status driver ok", `REG_STATUS, 32'hf);
		read_expect("status driver ok", `REG_STATUS, 32'hf);

		// queue configuration
		for (int i = 0; i < 6; i++)
		begin
			rnd[i] = $random(seed);
			write_reg("ring address", ring_regs[i], rnd[i]);
		end
		write_reg("queue ready", `REG_QUEUE_READY, 32'd1);
		compare_value("vq desc lo", rnd[0], vq_cfg.desc[31:0]);
		compare_value("vq desc hi", rnd[1], vq_cfg.desc[63:32]);
		compare_value("vq avail lo", rnd[2], vq_cfg.avail[31:0]);
		compare_value("vq avail hi", rnd[3], vq_cfg.avail[63:32]);
		compare_value("vq used lo", rnd[4], vq_cfg.used[31:0]);
		compare_value("vq used hi", rnd[5], vq_cfg.used[63:32]);
		compare_value("vq ready", 32'd1, 32'(vq_cfg.ready));
		read_expect("queue ready", `REG_QUEUE_READY, 32'd1);

		// notify, interrupt and acknowledge
		compare_value("interrupt before notify", 32'd0, 32'(interrupt));
		notify_base = notify_count;
		write_reg("queue notify", `REG_QUEUE_NOTIFY, 32'd0);
		waited = 0;
		while (notify_count == notify_base && waited < TIMEOUT)
		begin
			@(posedge axi_aclk);
			waited++;
		end
		if (notify_count == notify_base)
			stop_with_failure("queue_notify never pulsed after the notify write");
		repeat (4) @(posedge axi_aclk);
		compare_value("notify pulses", 32'd1, notify_count - notify_base);
		compare_value("interrupt after notify", 32'd1, 32'(interrupt));
		read_expect("int status", `REG_INT_STATUS, 32'd1);
		write_reg("int ack", `REG_INT_ACK, 32'd1);
		compare_value("interrupt after ack", 32'd0, 32'(interrupt));
		read_expect("int status after ack", `REG_INT_STATUS, 32'd0);

		repeat (3) @(posedge axi_aclk);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hw
hw/virtio_pkg.sv
hw/virtio_axi_slave.sv
hw/virtio_status_fsm.sv
hw/virtio_regfile.sv
hw/virtio_mmio_top.sv
sim/tb_virtio_mmio.sv

//--- run_sim.sh
#!/bin/sh
# build and run the virtio-mmio testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module tb_virtio_mmio &&
./obj_dir/Vtb_virtio_mmio > sim.log 2>&1 ||
echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx -- ">>> PASS" sim.log && echo "result: passed" || { echo "result: failed"; exit 1; }
